// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= packet_mem_tb
FILELIST  ?= packet_mem.f
BUILD_DIR ?= obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard bench/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/packet_mem_model.svh
`ifndef packet_mem_model_svh
`define packet_mem_model_svh

// program words in load order, partial trailing bits excluded
packet_pkg::packet_t prog_q [$];

// words still owed on mem2fifo_packet, oldest first
packet_pkg::packet_t expect_q [$];

// write-backs accepted since the stream last started
int wb_count;

function automatic void clear_program();
    prog_q.delete();
endfunction

function automatic void add_program_word(input packet_pkg::packet_t word);
    prog_q.push_back(word);
endfunction

// stream and replay both deliver the program from word 0
function automatic void restart_stream();
    expect_q = prog_q;
    wb_count = 0;
endfunction

// datapath beats the edge pes, lowest edge index beats the other edges
function automatic void record_write_back(
    input logic                  dp_v,
    input packet_pkg::packet_t   dp_p,
    input packet_pkg::edge_vec_t ev,
    input packet_pkg::packet_t   ep [packet_pkg::num_edge_pe]
);
    logic taken;
    taken = 1'b0;
    if (dp_v) begin
        expect_q.push_back(dp_p);
        taken = 1'b1;
    end
    for (int i = 0; i < packet_pkg::num_edge_pe; i++) begin
        if (ev[i] && !taken) begin
            expect_q.push_back(ep[i]);
            taken = 1'b1;
        end
    end
    if (taken) begin
        wb_count++;
    end
endfunction

`endif

// File: bench/packet_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module packet_mem_tb;

    logic                  clk;
    logic                  reset;
    logic                  bank_data;
    logic                  sos;
    logic                  eos;
    logic                  dp_valid;
    packet_pkg::packet_t   dp_packet;
    packet_pkg::edge_vec_t edge_valid;
    packet_pkg::packet_t   edge_packets [packet_pkg::num_edge_pe];
    logic                  full;
    logic                  fifo_stall;
    logic                  cntl_done;
    logic                  replay_iter_flag;
    logic                  mem2fifo_valid;
    packet_pkg::packet_t   mem2fifo_packet;
    logic                  sram_cen;

    integer seed;
    int     delivered;

    `include "packet_mem_model.svh"

    packet_mem_top uut (
        .clk              (clk),
        .reset            (reset),
        .bank_data        (bank_data),
        .sos              (sos),
        .eos              (eos),
        .dp_valid         (dp_valid),
        .dp_packet        (dp_packet),
        .edge_valid       (edge_valid),
        .edge_packets     (edge_packets),
        .full             (full),
        .fifo_stall       (fifo_stall),
        .cntl_done        (cntl_done),
        .replay_iter_flag (replay_iter_flag),
        .mem2fifo_valid   (mem2fifo_valid),
        .mem2fifo_packet  (mem2fifo_packet),
        .sram_cen         (sram_cen)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed);
        return lo + int'(r & 32'h7fffffff) % (hi - lo + 1);
    endfunction

    function automatic packet_pkg::packet_t rand_word();
        return packet_pkg::packet_t'($random(seed));
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic compare_packet(input string name, input packet_pkg::packet_t got,
                                  input packet_pkg::packet_t want);
        if (got !== want) begin
            stop_on_error($sformatf("Fail %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            stop_on_error($sformatf("Fail %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    // outputs are stable at the falling edge
    task automatic watch_output();
        packet_pkg::packet_t want;
        forever begin
            @(negedge clk);
            if (reset && mem2fifo_valid) begin
                delivered++;
                if (expect_q.size() == 0) begin
                    stop_on_error("a word was delivered while none was expected");
                end else begin
                    want = expect_q.pop_front();
                    compare_packet("mem2fifo_packet", mem2fifo_packet, want);
                end
            end
        end
    endtask

    task automatic drive_write_back(input logic allow);
        logic                  dp_v;
        packet_pkg::packet_t   dp_p;
        packet_pkg::edge_vec_t ev;
        packet_pkg::packet_t   ep [packet_pkg::num_edge_pe];
        dp_v = 1'b0;
        ev   = '0;
        dp_p = rand_word();
        for (int i = 0; i < packet_pkg::num_edge_pe; i++) begin
            ep[i] = rand_word();
        end
        // keeps the circular queue well short of wrapping
        if (allow && (prog_q.size() + wb_count < 200)) begin
            dp_v = (rand_range(0, 5) == 0);
            if (rand_range(0, 3) == 0) begin
                ev = packet_pkg::edge_vec_t'($random(seed) & $random(seed));
            end
        end
        dp_valid   <= dp_v;
        dp_packet  <= dp_p;
        edge_valid <= ev;
        for (int i = 0; i < packet_pkg::num_edge_pe; i++) begin
            edge_packets[i] <= ep[i];
        end
        record_write_back(dp_v, dp_p, ev, ep);
    endtask

    task automatic send_frame();
        int                  n_words;
        int                  n_extra;
        packet_pkg::packet_t word;
        n_words = rand_range(5, 40);
        n_extra = rand_range(1, packet_pkg::packet_width - 1);
        clear_program();
        sos <= 1'b1;
        for (int i = 0; i < n_words; i++) begin
            word = rand_word();
            add_program_word(word);
            // msb first
            for (int b = packet_pkg::packet_width - 1; b >= 0; b--) begin
                @(posedge clk);
                sos       <= 1'b0;
                bank_data <= word[b];
            end
        end
        // partial word, never loaded
        for (int b = 0; b < n_extra; b++) begin
            @(posedge clk);
            bank_data <= (rand_range(0, 1) == 1);
        end
        @(posedge clk);
        bank_data <= 1'b0;
        eos       <= 1'b1;
        restart_stream();
        @(posedge clk);
        eos <= 1'b0;
    endtask

    task automatic hold_back_pressure(input logic use_stall);
        int cycles;
        int first;
        cycles = rand_range(3, 8);
        if (use_stall) begin
            fifo_stall <= 1'b1;
        end else begin
            full <= 1'b1;
        end
        drive_write_back(1'b1);
        @(posedge clk);
        first = delivered;
        for (int i = 1; i < cycles; i++) begin
            drive_write_back(1'b1);
            @(posedge clk);
        end
        full       <= 1'b0;
        fifo_stall <= 1'b0;
        if (delivered - first > 2) begin
            stop_on_error("more than two words were delivered while read-out was held back");
        end
    endtask

    task automatic stream_phase();
        int cycles;
        cycles = rand_range(40, 80);
        for (int i = 0; i < cycles; i++) begin
            if (i == cycles / 3) begin
                hold_back_pressure(1'b0);
            end else if (i == 2 * cycles / 3) begin
                hold_back_pressure(1'b1);
            end
            drive_write_back(1'b1);
            @(posedge clk);
        end
        drive_write_back(1'b0);
        @(posedge clk);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((expect_q.size() != 0) && (waited < 3000)) begin
            @(posedge clk);
            waited++;
        end
        if (expect_q.size() != 0) begin
            stop_on_error("timed out waiting for the queued words to be delivered");
        end
        // room for any stray word to show up
        repeat (4) @(posedge clk);
    endtask

    task automatic park_controller();
        cntl_done <= 1'b1;
        @(posedge clk);
        cntl_done <= 1'b0;
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            compare_bit("sram_cen", sram_cen, 1'b1);
            compare_bit("mem2fifo_valid", mem2fifo_valid, 1'b0);
        end
        @(posedge clk);
    endtask

    initial begin
        seed             = 32'hcfb716f4;
        reset            = 1'b0;
        bank_data        = 1'b0;
        sos              = 1'b0;
        eos              = 1'b0;
        dp_valid         = 1'b0;
        dp_packet        = '0;
        edge_valid       = '0;
        full             = 1'b0;
        fifo_stall       = 1'b0;
        cntl_done        = 1'b0;
        replay_iter_flag = 1'b0;
        delivered        = 0;
        for (int i = 0; i < packet_pkg::num_edge_pe; i++) begin
            edge_packets[i] = '0;
        end
        fork
            watch_output();
        join_none
        repeat (4) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        compare_bit("mem2fifo_valid", mem2fifo_valid, 1'b0);
        compare_bit("sram_cen", sram_cen, 1'b0);
        @(posedge clk);
        // second frame reloads from the parked state
        for (int frame = 0; frame < 2; frame++) begin
            send_frame();
            if (frame == 0) begin
                stream_phase();
                wait_drained();
            end else begin
                // park with program reads still in flight
                repeat (3) @(posedge clk);
            end
            park_controller();
            replay_iter_flag <= 1'b1;
            restart_stream();
            @(posedge clk);
            replay_iter_flag <= 1'b0;
            stream_phase();
            wait_drained();
            park_controller();
        end
        if (expect_q.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_on_error("expected words were never delivered");
        end
    end

endmodule

`default_nettype wire

// File: logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // packet sram geometry
    localparam int mem_depth = 256;
    localparam int addr_width = $clog2(mem_depth);

    // one extra bit so a full load of 256 fits
    localparam int count_width = addr_width + 1;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [count_width-1:0] count_t;

    typedef enum logic [2:0] {
        idle            = 3'd0,
        prepare         = 3'd1,
        stream          = 3'd2,
        wait_fifo_stall = 3'd3,
        stall           = 3'd4
    } cntl_state_t;

endpackage

`default_nettype wire

// File: logic/packet_cntl.sv
`timescale 1ns/1ps
`default_nettype none

module packet_cntl (
    input  logic           clk,
    input  logic           reset,
    input  logic           sos,
    input  logic           eos,
    input  logic           word_valid,
    input  logic           full,
    input  logic           fifo_stall,
    input  logic           cntl_done,
    input  logic           replay_iter_flag,
    input  logic           load_grant,
    input  logic           wb_grant,
    input  logic           read_grant,
    output logic           load_req,
    output mem_pkg::addr_t load_addr,
    output logic           wb_enable,
    output mem_pkg::addr_t wr_addr,
    output logic           read_req,
    output mem_pkg::addr_t rd_addr,
    output logic           cen_hold,
    output logic           mem2fifo_valid
);

    mem_pkg::cntl_state_t state;
    mem_pkg::cntl_state_t state_next;
    mem_pkg::count_t      load_cnt;
    mem_pkg::count_t      load_len;
    mem_pkg::count_t      load_total;
    mem_pkg::addr_t       wr_ptr;
    mem_pkg::addr_t       rd_ptr;
    logic                 replay;
    logic                 rd_pending;

    assign replay = replay_iter_flag &&
                    (state != mem_pkg::idle) && (state != mem_pkg::prepare);

    // words beyond the sram depth are dropped
    assign load_req   = (state == mem_pkg::prepare) && word_valid &&
                        (load_cnt < mem_pkg::count_t'(mem_pkg::mem_depth));
    assign load_addr  = mem_pkg::addr_t'(load_cnt);
    assign load_total = load_cnt + mem_pkg::count_t'(load_grant);

    assign wb_enable = (state == mem_pkg::stream) || (state == mem_pkg::wait_fifo_stall);
    assign read_req  = (state == mem_pkg::stream) && !full && !replay_iter_flag &&
                       (rd_ptr != wr_ptr);
    assign cen_hold  = (state == mem_pkg::stall);

    assign wr_addr = wr_ptr;
    assign rd_addr = rd_ptr;

    always_comb begin
        state_next = state;
        case (state)
            mem_pkg::idle: begin
                if (sos) begin
                    state_next = mem_pkg::prepare;
                end
            end
            mem_pkg::prepare: begin
                // final word, if any, is written on the eos cycle
                if (eos) begin
                    state_next = mem_pkg::stream;
                end
            end
            mem_pkg::stream: begin
                if (cntl_done) begin
                    state_next = mem_pkg::stall;
                end else if (fifo_stall) begin
                    state_next = mem_pkg::wait_fifo_stall;
                end
            end
            mem_pkg::wait_fifo_stall: begin
                if (!fifo_stall) begin
                    state_next = mem_pkg::stream;
                end
            end
            mem_pkg::stall: begin
                // a new frame reloads the program
                if (sos) begin
                    state_next = mem_pkg::prepare;
                end
            end
            default: begin
                state_next = mem_pkg::idle;
            end
        endcase
        if (replay) begin
            state_next = mem_pkg::stream;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state          <= mem_pkg::idle;
            load_cnt       <= '0;
            load_len       <= '0;
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            rd_pending     <= 1'b0;
            mem2fifo_valid <= 1'b0;
        end else begin
            state <= state_next;

            // sram cycle, then output register
            rd_pending     <= read_grant;
            mem2fifo_valid <= rd_pending && !replay_iter_flag &&
                              (state_next != mem_pkg::stall);

            if (sos && (state_next == mem_pkg::prepare)) begin
                load_cnt <= '0;
            end else if (load_grant) begin
                load_cnt <= load_cnt + 1'b1;
            end

            if ((state == mem_pkg::prepare) && eos) begin
                load_len <= load_total;
                wr_ptr   <= mem_pkg::addr_t'(load_total);
                rd_ptr   <= '0;
            end else if (replay) begin
                wr_ptr <= mem_pkg::addr_t'(load_len);
                rd_ptr <= '0;
            end else begin
                // circular queue, wraps at the sram depth
                if (wb_grant) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (read_grant) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    a_no_valid_in_stall: assert property (
        @(posedge clk) disable iff (!reset)
        $rose(mem2fifo_valid) |-> (state != mem_pkg::stall)
    );

    a_no_read_when_full: assert property (
        @(posedge clk) disable iff (!reset)
        full |-> !(read_req || read_grant)
    );

endmodule

`default_nettype wire

// File: logic/packet_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module packet_mem_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  bank_data,
    input  logic                  sos,
    input  logic                  eos,
    input  logic                  dp_valid,
    input  packet_pkg::packet_t   dp_packet,
    input  packet_pkg::edge_vec_t edge_valid,
    input  packet_pkg::packet_t   edge_packets [packet_pkg::num_edge_pe],
    input  logic                  full,
    input  logic                  fifo_stall,
    input  logic                  cntl_done,
    input  logic                  replay_iter_flag,
    output logic                  mem2fifo_valid,
    output packet_pkg::packet_t   mem2fifo_packet,
    output logic                  sram_cen
);

    logic                word_valid;
    packet_pkg::packet_t word_data;
    logic                load_req;
    mem_pkg::addr_t      load_addr;
    logic                wb_enable;
    mem_pkg::addr_t      wr_addr;
    logic                read_req;
    mem_pkg::addr_t      rd_addr;
    logic                cen_hold;
    logic                load_grant;
    logic                wb_grant;
    logic                read_grant;
    logic                sram_wen;
    mem_pkg::addr_t      sram_addr;
    packet_pkg::packet_t sram_wdata;

    packet_rx u_rx (
        .clk        (clk),
        .reset      (reset),
        .bank_data  (bank_data),
        .sos        (sos),
        .eos        (eos),
        .word_valid (word_valid),
        .word_data  (word_data)
    );

    packet_cntl u_cntl (
        .clk              (clk),
        .reset            (reset),
        .sos              (sos),
        .eos              (eos),
        .word_valid       (word_valid),
        .full             (full),
        .fifo_stall       (fifo_stall),
        .cntl_done        (cntl_done),
        .replay_iter_flag (replay_iter_flag),
        .load_grant       (load_grant),
        .wb_grant         (wb_grant),
        .read_grant       (read_grant),
        .load_req         (load_req),
        .load_addr        (load_addr),
        .wb_enable        (wb_enable),
        .wr_addr          (wr_addr),
        .read_req         (read_req),
        .rd_addr          (rd_addr),
        .cen_hold         (cen_hold),
        .mem2fifo_valid   (mem2fifo_valid)
    );

    sram_arbiter u_arb (
        .clk          (clk),
        .reset        (reset),
        .load_req     (load_req),
        .load_data    (word_data),
        .load_addr    (load_addr),
        .wb_enable    (wb_enable),
        .dp_valid     (dp_valid),
        .dp_packet    (dp_packet),
        .edge_valid   (edge_valid),
        .edge_packets (edge_packets),
        .wr_addr      (wr_addr),
        .read_req     (read_req),
        .rd_addr      (rd_addr),
        .cen_hold     (cen_hold),
        .load_grant   (load_grant),
        .wb_grant     (wb_grant),
        .read_grant   (read_grant),
        .sram_cen     (sram_cen),
        .sram_wen     (sram_wen),
        .sram_addr    (sram_addr),
        .sram_wdata   (sram_wdata)
    );

    packet_sram u_sram (
        .clk        (clk),
        .sram_cen   (sram_cen),
        .sram_wen   (sram_wen),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .rdata      (mem2fifo_packet)
    );

endmodule

`default_nettype wire

// File: logic/packet_pkg.sv
`default_nettype none

package packet_pkg;

    // packet word
    localparam int packet_width = 16;

    typedef logic [packet_width-1:0] packet_t;

    // edge processing elements feeding write-backs
    localparam int num_edge_pe = 4;

    typedef logic [num_edge_pe-1:0] edge_vec_t;

    // serial frame, one bit per cycle, msb first
    localparam int bit_cnt_width = $clog2(packet_width);
    localparam int last_bit = packet_width - 1;

    typedef logic [bit_cnt_width-1:0] bit_cnt_t;

endpackage

`default_nettype wire

// File: logic/packet_rx.sv
`timescale 1ns/1ps
`default_nettype none

module packet_rx (
    input  logic                clk,
    input  logic                reset,
    input  logic                bank_data,
    input  logic                sos,
    input  logic                eos,
    output logic                word_valid,
    output packet_pkg::packet_t word_data
);

    logic                 in_frame;
    logic                 sample;
    packet_pkg::bit_cnt_t bit_cnt;
    packet_pkg::packet_t  shift_reg;

    // data bits only between sos and eos
    assign sample = in_frame && !sos && !eos;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            in_frame   <= 1'b0;
            bit_cnt    <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= sample &&
                          (bit_cnt == packet_pkg::bit_cnt_t'(packet_pkg::last_bit));
            if (sos) begin
                in_frame <= 1'b1;
                bit_cnt  <= '0;
            end else if (eos) begin
                // partial word is dropped here
                in_frame <= 1'b0;
                bit_cnt  <= '0;
            end else if (sample) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            shift_reg <= {shift_reg[packet_pkg::packet_width-2:0], bank_data};
        end
    end

    // stable for the cycle word_valid is high
    assign word_data = shift_reg;

    // completed words only surface while the frame is still open
    a_valid_in_frame: assert property (
        @(posedge clk) disable iff (!reset)
        word_valid |-> in_frame
    );

endmodule

`default_nettype wire

// File: logic/packet_sram.sv
`timescale 1ns/1ps
`default_nettype none

module packet_sram (
    input  logic                clk,
    input  logic                sram_cen,
    input  logic                sram_wen,
    input  mem_pkg::addr_t      sram_addr,
    input  packet_pkg::packet_t sram_wdata,
    output packet_pkg::packet_t rdata
);

    packet_pkg::packet_t mem [mem_pkg::mem_depth];
    packet_pkg::packet_t rd_q;

    // single port, cen low enables, wen low writes
    always_ff @(posedge clk) begin
        if (!sram_cen) begin
            if (!sram_wen) begin
                mem[sram_addr] <= sram_wdata;
            end else begin
                rd_q <= mem[sram_addr];
            end
        end
    end

    // output register toward the fifo
    // lines data up with the registered valid in the controller
    always_ff @(posedge clk) begin
        rdata <= rd_q;
    end

endmodule

`default_nettype wire

// File: logic/sram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module sram_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load_req,
    input  packet_pkg::packet_t   load_data,
    input  mem_pkg::addr_t        load_addr,
    input  logic                  wb_enable,
    input  logic                  dp_valid,
    input  packet_pkg::packet_t   dp_packet,
    input  packet_pkg::edge_vec_t edge_valid,
    input  packet_pkg::packet_t   edge_packets [packet_pkg::num_edge_pe],
    input  mem_pkg::addr_t        wr_addr,
    input  logic                  read_req,
    input  mem_pkg::addr_t        rd_addr,
    input  logic                  cen_hold,
    output logic                  load_grant,
    output logic                  wb_grant,
    output logic                  read_grant,
    output logic                  sram_cen,
    output logic                  sram_wen,
    output mem_pkg::addr_t        sram_addr,
    output packet_pkg::packet_t   sram_wdata
);

    logic                dp_win;
    logic                edge_win;
    logic                wb_any;
    logic                edge_hit;
    packet_pkg::packet_t edge_data;

    always_comb begin
        edge_hit  = 1'b0;
        edge_data = '0;
        // scan downward so the lowest index wins
        for (int i = packet_pkg::num_edge_pe - 1; i >= 0; i--) begin
            if (edge_valid[i]) begin
                edge_hit  = 1'b1;
                edge_data = edge_packets[i];
            end
        end
    end

    // load, then datapath, then edge pe, then read
    assign wb_any   = wb_enable && (dp_valid || edge_hit);
    assign dp_win   = wb_enable && dp_valid && !cen_hold && !load_req;
    assign edge_win = wb_enable && edge_hit && !dp_valid && !cen_hold && !load_req;

    assign load_grant = load_req && !cen_hold;
    assign wb_grant   = dp_win || edge_win;
    assign read_grant = read_req && !cen_hold && !load_req && !wb_any;

    always_comb begin
        sram_addr  = rd_addr;
        sram_wdata = '0;
        if (load_grant) begin
            sram_addr  = load_addr;
            sram_wdata = load_data;
        end else if (dp_win) begin
            sram_addr  = wr_addr;
            sram_wdata = dp_packet;
        end else if (edge_win) begin
            sram_addr  = wr_addr;
            sram_wdata = edge_data;
        end
    end

    // wen low means write
    assign sram_wen = !(load_grant || wb_grant);
    assign sram_cen = cen_hold;

    a_one_grant: assert property (
        @(posedge clk) disable iff (!reset)
        $onehot0({load_grant, wb_grant, read_grant})
    );

endmodule

`default_nettype wire

// File: packet_mem.f
+incdir+bench
logic/packet_pkg.sv
logic/mem_pkg.sv
logic/packet_rx.sv
logic/sram_arbiter.sv
logic/packet_sram.sv
logic/packet_cntl.sv
logic/packet_mem_top.sv
bench/packet_mem_tb.sv
